// File: logic/iob_cfg.svh
/* board constants; the divisors assume a 50 MHz clk
   and each is the cycle count per tick minus one */
`ifndef IOB_CFG_SVH
`define IOB_CFG_SVH

// 64-word block, low 6 address bits select the register
`define IOB_BASE 22'o17772000

// clk cycles per microsecond, minus one
`define IOB_US_DIV 49

// clk cycles per 60 Hz period, minus one
`define IOB_HZ60_DIV 833332

// keyboard and mouse share one vector
`define IOB_VEC_INPUT 8'o260

// tick clock vector
`define IOB_VEC_CLOCK 8'o274

`endif

// File: logic/xbus_pkg.sv
/* bus-side types of the Xbus slave port
   word addresses are 22 bits, data words 32 bits */
package xbus_pkg;

   // word address on the bus
   typedef logic [21:0] xbus_addr_t;

   // one bus data word
   typedef logic [31:0] xbus_data_t;

   // request as the master presents it, held until ack
   typedef struct packed {
      xbus_addr_t addr;
      xbus_data_t wdata;
      logic       write;
   } xbus_req_s;

endpackage

// File: logic/iob_pkg.sv
/* board-side types: register map, the stage 1 to stage 2 access
   and the device event bundles */
package iob_pkg;

   // register offset inside the block
   typedef logic [5:0] iob_off_t;

   typedef logic [15:0] iob_scan_t;
   typedef logic [11:0] iob_coord_t;
   typedef logic [2:0]  iob_btn_t;
   typedef logic [2:0]  iob_rdy_t;
   typedef logic [3:0]  iob_csr_t;

   localparam iob_off_t KBD_LO  = 6'o40;
   localparam iob_off_t KBD_HI  = 6'o41;
   localparam iob_off_t MS_Y    = 6'o42;
   localparam iob_off_t MS_X    = 6'o43;
   localparam iob_off_t BEEP    = 6'o44;
   localparam iob_off_t CSR     = 6'o45;
   localparam iob_off_t USEC_LO = 6'o50;
   localparam iob_off_t USEC_HI = 6'o51;
   localparam iob_off_t HZ60    = 6'o52;

   // ready bit order; the enable for each sits one bit higher in the CSR
   localparam int RDY_MS  = 0;
   localparam int RDY_KB  = 1;
   localparam int RDY_CLK = 2;

   typedef struct packed {
      logic                 valid;
      logic                 write;
      iob_off_t             offset;
      xbus_pkg::xbus_data_t wdata;
   } iob_access_s;

   typedef struct packed {
      iob_scan_t code;
      logic      ready;
   } kb_event_s;

   // buttons are head, middle, tail from bit 2 down
   typedef struct packed {
      iob_coord_t x;
      iob_coord_t y;
      iob_btn_t   buttons;
      logic       ready;
   } ms_event_s;

   typedef enum logic [1:0] {IDLE, BUSY, DONE} iob_phase_e;

endpackage

// File: bench/iob_tb.sv
/* testbench for iob_top; must be compiled ahead of the RTL so that
   the shortened clock divisors below reach iob_timers */
`timescale 1ns/10ps
`include "iob_cfg.svh"

// short prescalers so both clocks tick within the run
`undef IOB_US_DIV
`define IOB_US_DIV 4
`undef IOB_HZ60_DIV
`define IOB_HZ60_DIV 99

module iob_tb;

   localparam xbus_pkg::xbus_addr_t base_addr = `IOB_BASE;
   localparam int us_period = `IOB_US_DIV + 1;
   localparam int hz60_period = `IOB_HZ60_DIV + 1;
   // every access costs 3 cycles of latency plus slack, then the clock test waits
   localparam int access_count = 200;
   localparam int clock_waits = 150 + 200 + 350 + hz60_period + 20;
   localparam int cycle_limit = access_count * (3 + 4) + clock_waits + 200;

   logic                 clk;
   logic                 reset;
   logic                 req;
   xbus_pkg::xbus_req_s  bus;
   logic                 decode;
   logic                 ack;
   xbus_pkg::xbus_data_t dataout;
   iob_pkg::kb_event_s   kb;
   iob_pkg::ms_event_s   ms;
   logic                 interrupt;
   logic [7:0]           vector;

   // shadow of the board state
   logic [15:0]          sh_kb_code;
   logic [11:0]          sh_ms_x;
   logic [11:0]          sh_ms_y;
   logic [2:0]           sh_ms_btn;
   logic [3:0]           sh_csr;
   logic [2:0]           sh_rdy;

   logic                 expect_on;
   xbus_pkg::xbus_data_t expect_word;
   int                   last_start;
   int                   cycle_count;
   int                   errors;
   int                   checks;
   int                   tests_run;
   int                   tests_failed;
   int                   errors_at_start;

   iob_top iob_top_inst (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .bus       (bus),
      .decode    (decode),
      .ack       (ack),
      .dataout   (dataout),
      .kb        (kb),
      .ms        (ms),
      .interrupt (interrupt),
      .vector    (vector)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("run stopped after %0d cycles, a test did not finish", cycle_count);
         $display("Result: FAILED");
         $finish;
      end
   end

   function automatic xbus_pkg::xbus_data_t expected_read(input iob_pkg::iob_off_t off);
      case (off)
         iob_pkg::KBD_LO: return {16'b0, sh_kb_code};
         iob_pkg::MS_Y:   return {17'b0, sh_ms_btn, sh_ms_y};
         iob_pkg::MS_X:   return {20'b0, sh_ms_x};
         iob_pkg::CSR:    return {25'b0, sh_rdy, sh_csr};
         // HZ60 is only predicted before the tick clock starts
         default:         return '0;
      endcase
   endfunction

   // interrupt in bit 8, vector below it
   function automatic logic [8:0] expected_irq();
      logic ms_i;
      logic kb_i;
      logic clk_i;
      ms_i = sh_rdy[0] & sh_csr[1];
      kb_i = sh_rdy[1] & sh_csr[2];
      clk_i = sh_rdy[2] & sh_csr[3];
      if (ms_i || kb_i)
         return {1'b1, `IOB_VEC_INPUT};
      else if (clk_i)
         return {1'b1, `IOB_VEC_CLOCK};
      else
         return 9'd0;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      checks++;
      if (got !== expected)
      begin
         $display("FAILED %0t %s got %h expected %h", $time, name, got, expected);
         errors++;
      end
   endtask

   // data in every ack cycle, zero outside it
   always @(negedge clk)
   begin
      if (!reset)
      begin
         if (ack && expect_on)
            check_value("dataout", dataout, expect_word);
         else if (!ack)
            check_value("dataout", dataout, 32'd0);
      end
   end

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic run_access(input logic write, input iob_pkg::iob_off_t off,
                             input xbus_pkg::xbus_data_t wdata, input logic kb_pulse,
                             output xbus_pkg::xbus_data_t rdata);
      int n;
      n = 0;
      rdata = '0;
      bus.addr = {base_addr[21:6], off};
      bus.wdata = wdata;
      bus.write = write;
      last_start = cycle_count;
      req = 1'b1;
      while (!ack && n < 10)
      begin
         @(negedge clk);
         n++;
         // strobe held across the edge of the read-clear
         kb.ready = kb_pulse && (n == 1);
      end
      if (ack)
      begin
         rdata = dataout;
         check_value("ack_latency", n, 3);
      end
      else
      begin
         $display("ack never came for offset %o at %0t", off, $time);
         errors++;
      end
      req = 1'b0;
      @(negedge clk);
   endtask

   task automatic bus_write(input iob_pkg::iob_off_t off, input xbus_pkg::xbus_data_t wdata);
      xbus_pkg::xbus_data_t unused;
      expect_word = '0;
      expect_on = 1'b1;
      run_access(1'b1, off, wdata, 1'b0, unused);
      expect_on = 1'b0;
      if (off == iob_pkg::CSR)
         sh_csr = wdata[3:0];
   endtask

   task automatic bus_read(input iob_pkg::iob_off_t off, input logic check,
                           input logic kb_pulse, output xbus_pkg::xbus_data_t rdata);
      expect_word = expected_read(off);
      expect_on = check;
      run_access(1'b0, off, '0, kb_pulse, rdata);
      expect_on = 1'b0;
      if (off == iob_pkg::KBD_LO || off == iob_pkg::KBD_HI)
         sh_rdy[1] = 1'b0;
      if (off == iob_pkg::MS_Y)
         sh_rdy[0] = 1'b0;
      if (off == iob_pkg::HZ60)
         sh_rdy[2] = 1'b0;
      // a same-cycle event sets the flag again
      if (kb_pulse)
      begin
         sh_kb_code = kb.code;
         sh_rdy[1] = 1'b1;
      end
   endtask

   task automatic kb_strobe(input logic [15:0] code);
      kb.code = code;
      kb.ready = 1'b1;
      @(negedge clk);
      kb.ready = 1'b0;
      sh_kb_code = code;
      sh_rdy[1] = 1'b1;
   endtask

   task automatic ms_strobe(input logic [11:0] x, input logic [11:0] y, input logic [2:0] btn);
      ms.x = x;
      ms.y = y;
      ms.buttons = btn;
      ms.ready = 1'b1;
      @(negedge clk);
      ms.ready = 1'b0;
      sh_ms_x = x;
      sh_ms_y = y;
      sh_ms_btn = btn;
      sh_rdy[0] = 1'b1;
   endtask

   // all 16 enable patterns for each keyboard and mouse ready mix
   task automatic check_interrupts();
      xbus_pkg::xbus_data_t rd;
      logic [31:0] r;
      logic [8:0] irq;
      for (int mix = 0; mix < 4; mix++)
      begin
         r = $urandom;
         kb_strobe(r[15:0]);
         ms_strobe(r[27:16], r[11:0], r[30:28]);
         if (!mix[0])
            bus_read(iob_pkg::MS_Y, 1'b1, 1'b0, rd);
         if (!mix[1])
            bus_read(iob_pkg::KBD_LO, 1'b1, 1'b0, rd);
         for (int en = 0; en < 16; en++)
         begin
            bus_write(iob_pkg::CSR, en);
            irq = expected_irq();
            check_value("interrupt", interrupt, irq[8]);
            check_value("vector", vector, irq[7:0]);
         end
      end
   endtask

   task automatic start_test();
      errors_at_start = errors;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors != errors_at_start)
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - errors_at_start);
      end
      else
         $display("test %s: ok", name);
   endtask

   initial
   begin
      xbus_pkg::xbus_data_t rd;
      xbus_pkg::xbus_data_t rd2;
      logic [31:0] r;
      int acks;
      int s1;
      int k;
      int delta;
      clk = 1'b0;
      reset = 1'b1;
      req = 1'b0;
      bus = '0;
      kb = '0;
      ms = '0;
      expect_on = 1'b0;
      expect_word = '0;
      {sh_kb_code, sh_ms_x, sh_ms_y, sh_ms_btn, sh_csr, sh_rdy} = '0;
      {last_start, cycle_count} = '0;
      {errors, checks, tests_run, tests_failed, errors_at_start} = '0;
      void'($urandom(32'h2c99_c456));
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      start_test();
      for (int i = 0; i < 6; i++)
      begin
         bus_write(iob_pkg::CSR, $urandom);
         bus_read(iob_pkg::CSR, 1'b1, 1'b0, rd);
      end
      // req held well past ack still gives one ack
      bus.addr = {base_addr[21:6], iob_pkg::CSR};
      bus.write = 1'b0;
      expect_word = expected_read(iob_pkg::CSR);
      expect_on = 1'b1;
      acks = 0;
      req = 1'b1;
      repeat (12)
      begin
         @(negedge clk);
         if (ack)
            acks++;
      end
      req = 1'b0;
      @(negedge clk);
      expect_on = 1'b0;
      check_value("ack_count", acks, 1);
      finish_test("csr");

      start_test();
      r = $urandom;
      kb_strobe(r[15:0]);
      bus_read(iob_pkg::CSR, 1'b1, 1'b0, rd);
      bus_read(iob_pkg::KBD_LO, 1'b1, 1'b0, rd);
      bus_read(iob_pkg::CSR, 1'b1, 1'b0, rd);
      bus_read(iob_pkg::KBD_HI, 1'b1, 1'b0, rd);
      r = $urandom;
      kb_strobe(r[15:0]);
      r = $urandom;
      kb.code = r[15:0];
      bus_read(iob_pkg::KBD_LO, 1'b1, 1'b1, rd);
      bus_read(iob_pkg::CSR, 1'b1, 1'b0, rd);
      bus_read(iob_pkg::KBD_LO, 1'b1, 1'b0, rd);
      finish_test("keyboard");

      start_test();
      for (int i = 0; i < 3; i++)
      begin
         r = $urandom;
         ms_strobe(r[11:0], r[23:12], r[26:24]);
         bus_read(iob_pkg::MS_X, 1'b1, 1'b0, rd);
         bus_read(iob_pkg::CSR, 1'b1, 1'b0, rd);
         bus_read(iob_pkg::MS_Y, 1'b1, 1'b0, rd);
         bus_read(iob_pkg::CSR, 1'b1, 1'b0, rd);
      end
      finish_test("mouse");

      start_test();
      check_interrupts();
      finish_test("interrupts with clock idle");

      start_test();
      wait_cycles(150);
      bus_read(iob_pkg::USEC_LO, 1'b0, 1'b0, rd);
      s1 = last_start;
      wait_cycles(200);
      bus_read(iob_pkg::USEC_LO, 1'b0, 1'b0, rd2);
      k = last_start - s1;
      delta = rd2[15:0] - rd[15:0];
      check_value("usec_delta_in_range",
         (delta >= k / us_period - 1) && (delta <= (k + us_period - 1) / us_period + 1), 1);
      // tick count still zero, and this read starts it
      bus_read(iob_pkg::HZ60, 1'b1, 1'b0, rd);
      wait_cycles(350);
      sh_rdy[2] = 1'b1;
      bus_read(iob_pkg::CSR, 1'b1, 1'b0, rd);
      bus_read(iob_pkg::HZ60, 1'b0, 1'b0, rd);
      check_value("hz60_count_in_range", (rd >= 2) && (rd <= 4), 1);
      // next tick sets clock ready again
      wait_cycles(hz60_period + 20);
      sh_rdy[2] = 1'b1;
      bus_read(iob_pkg::CSR, 1'b1, 1'b0, rd);
      finish_test("clocks");

      start_test();
      check_interrupts();
      finish_test("interrupts with clock ready");

      start_test();
      bus.addr = {base_addr[21:6] + 16'd1, iob_pkg::CSR};
      bus.write = 1'b0;
      acks = 0;
      req = 1'b1;
      repeat (10)
      begin
         @(negedge clk);
         check_value("decode", decode, 0);
         if (ack)
            acks++;
      end
      req = 1'b0;
      @(negedge clk);
      check_value("ack_count", acks, 0);
      bus_write(iob_pkg::BEEP, $urandom);
      bus_read(iob_pkg::BEEP, 1'b1, 1'b0, rd);
      bus_read(6'o00, 1'b1, 1'b0, rd);
      bus_read(6'o46, 1'b1, 1'b0, rd);
      bus_read(6'o53, 1'b1, 1'b0, rd);
      bus_read(6'o77, 1'b1, 1'b0, rd);
      finish_test("address map");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: logic/iob_decode.sv
/* one access per held req; the master must drop req for a cycle
   after ack before the next request is taken */
`timescale 1ns/10ps
`include "iob_cfg.svh"

module iob_decode (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req,
   input  xbus_pkg::xbus_req_s  bus,
   output logic                 decode,
   output iob_pkg::iob_access_s access
);

   localparam xbus_pkg::xbus_addr_t base = `IOB_BASE;

   iob_pkg::iob_phase_e phase;

   // upper 16 address bits select the block
   assign decode = req && (bus.addr[21:6] == base[21:6]);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         phase <= iob_pkg::IDLE;
         access.valid <= 1'b0;
      end
      else
      begin
         access.valid <= 1'b0;
         case (phase)
            iob_pkg::IDLE:
            begin
               if (decode)
               begin
                  phase <= iob_pkg::BUSY;
                  access.valid <= 1'b1;
                  access.write <= bus.write;
                  access.offset <= bus.addr[5:0];
                  access.wdata <= bus.wdata;
               end
            end
            iob_pkg::BUSY:
               phase <= iob_pkg::DONE;
            // wait here until the master lets go of req
            iob_pkg::DONE:
            begin
               if (!req)
                  phase <= iob_pkg::IDLE;
            end
            default:
               phase <= iob_pkg::IDLE;
         endcase
      end
   end

   // a held req must never yield back-to-back accesses
   assert property (@(posedge clk) disable iff (reset) access.valid |=> !access.valid);

endmodule

// File: logic/iob_regs.sv
/* device latches, CSR and ready flags; a ready event in the same cycle
   as its clearing read leaves the flag set */
`timescale 1ns/10ps
`include "iob_cfg.svh"

module iob_regs (
   input  logic                 clk,
   input  logic                 reset,
   input  iob_pkg::iob_access_s access,
   input  iob_pkg::kb_event_s   kb,
   input  iob_pkg::ms_event_s   ms,
   input  xbus_pkg::xbus_data_t us_count,
   input  xbus_pkg::xbus_data_t hz60_count,
   input  logic                 hz60_tick,
   output logic                 hz60_start,
   output xbus_pkg::xbus_data_t rd_data,
   output logic                 done,
   output logic                 interrupt,
   output logic [7:0]           vector
);

   iob_pkg::iob_scan_t   kb_code;
   iob_pkg::iob_coord_t  ms_x;
   iob_pkg::iob_coord_t  ms_y;
   iob_pkg::iob_btn_t    ms_buttons;
   iob_pkg::iob_csr_t    csr;
   iob_pkg::iob_rdy_t    rdy;
   iob_pkg::iob_rdy_t    rdy_set;
   iob_pkg::iob_rdy_t    rdy_clr;
   xbus_pkg::xbus_data_t rd_word;
   logic                 rd_access;
   logic                 wr_access;
   logic                 ms_int;
   logic                 kb_int;
   logic                 clk_int;

   assign rd_access = access.valid && !access.write;
   assign wr_access = access.valid && access.write;

   // first HZ60 read starts the tick clock
   assign hz60_start = rd_access && (access.offset == iob_pkg::HZ60);

   // device latches
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         kb_code <= '0;
         ms_x <= '0;
         ms_y <= '0;
         ms_buttons <= '0;
      end
      else
      begin
         if (kb.ready)
            kb_code <= kb.code;
         if (ms.ready)
         begin
            ms_x <= ms.x;
            ms_y <= ms.y;
            ms_buttons <= ms.buttons;
         end
      end
   end

   assign rdy_set[iob_pkg::RDY_MS]  = ms.ready;
   assign rdy_set[iob_pkg::RDY_KB]  = kb.ready;
   assign rdy_set[iob_pkg::RDY_CLK] = hz60_tick;

   assign rdy_clr[iob_pkg::RDY_MS] = rd_access && (access.offset == iob_pkg::MS_Y);
   assign rdy_clr[iob_pkg::RDY_KB] = rd_access &&
      ((access.offset == iob_pkg::KBD_LO) || (access.offset == iob_pkg::KBD_HI));
   assign rdy_clr[iob_pkg::RDY_CLK] = hz60_start;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         csr <= '0;
         rdy <= '0;
      end
      else
      begin
         if (wr_access && (access.offset == iob_pkg::CSR))
            csr <= access.wdata[3:0];
         // set after clear, so the event wins
         rdy <= (rdy & ~rdy_clr) | rdy_set;
      end
   end

   // read word per offset
   always_comb
   begin
      case (access.offset)
         iob_pkg::KBD_LO:  rd_word = {16'b0, kb_code};
         iob_pkg::MS_Y:    rd_word = {17'b0, ms_buttons, ms_y};
         iob_pkg::MS_X:    rd_word = {20'b0, ms_x};
         iob_pkg::CSR:     rd_word = {25'b0, rdy, csr};
         iob_pkg::USEC_LO: rd_word = {16'b0, us_count[15:0]};
         iob_pkg::USEC_HI: rd_word = {16'b0, us_count[31:16]};
         iob_pkg::HZ60:    rd_word = hz60_count;
         // KBD_HI, BEEP and the unmapped rest read zero
         default:          rd_word = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         done <= 1'b0;
      else
         done <= access.valid;
   end

   always_ff @(posedge clk)
   begin
      rd_data <= rd_access ? rd_word : '0;
   end

   // enable bits sit one above their ready bits
   assign ms_int  = rdy[iob_pkg::RDY_MS]  & csr[iob_pkg::RDY_MS + 1];
   assign kb_int  = rdy[iob_pkg::RDY_KB]  & csr[iob_pkg::RDY_KB + 1];
   assign clk_int = rdy[iob_pkg::RDY_CLK] & csr[iob_pkg::RDY_CLK + 1];

   assign interrupt = ms_int | kb_int | clk_int;

   // input devices take priority over the clock
   assign vector = (ms_int || kb_int) ? `IOB_VEC_INPUT :
                   clk_int            ? `IOB_VEC_CLOCK :
                                        8'd0;

   assert property (@(posedge clk) disable iff (reset) interrupt |-> (vector != 8'd0));

endmodule

// File: logic/iob_timers.sv
/* microsecond count runs from reset; the 60 Hz count holds at zero
   until the first start strobe and never stops after that */
`timescale 1ns/10ps
`include "iob_cfg.svh"

module iob_timers (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 hz60_start,
   output xbus_pkg::xbus_data_t us_count,
   output xbus_pkg::xbus_data_t hz60_count,
   output logic                 hz60_tick
);

   logic [7:0]  us_div;
   logic [19:0] hz60_div;
   logic        hz60_on;
   logic        us_wrap;

   assign us_wrap = (us_div == 8'(`IOB_US_DIV));

   // end of a 60 Hz period, only once running
   assign hz60_tick = hz60_on && (hz60_div == 20'(`IOB_HZ60_DIV));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         us_div <= '0;
         us_count <= '0;
      end
      else if (us_wrap)
      begin
         us_div <= '0;
         us_count <= us_count + 32'd1;
      end
      else
         us_div <= us_div + 8'd1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         hz60_on <= 1'b0;
         hz60_div <= '0;
         hz60_count <= '0;
      end
      else
      begin
         if (hz60_start)
            hz60_on <= 1'b1;
         if (hz60_tick)
         begin
            hz60_div <= '0;
            hz60_count <= hz60_count + 32'd1;
         end
         else if (hz60_on)
            hz60_div <= hz60_div + 20'd1;
      end
   end

   // no tick is counted or prescaled before the first start
   assert property (@(posedge clk) disable iff (reset)
      !hz60_on |-> ((hz60_div == '0) && (hz60_count == '0)));

endmodule

// File: logic/iob_respond.sv
/* last pipeline stage; dataout is zero outside the ack cycle */
`timescale 1ns/10ps

module iob_respond (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 done,
   input  xbus_pkg::xbus_data_t rd_data,
   output logic                 ack,
   output xbus_pkg::xbus_data_t dataout
);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack <= 1'b0;
         dataout <= '0;
      end
      else
      begin
         ack <= done;
         // data only rides with ack
         if (done)
            dataout <= rd_data;
         else
            dataout <= '0;
      end
   end

   // the master sees exactly one ack per access
   assert property (@(posedge clk) disable iff (reset) ack |=> !ack);

endmodule

// File: logic/iob_top.sv
/* Xbus I/O board slave, fixed 3 cycle latency from req to ack;
   requests outside the block are never acked */
`timescale 1ns/10ps

module iob_top (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req,
   input  xbus_pkg::xbus_req_s  bus,
   output logic                 decode,
   output logic                 ack,
   output xbus_pkg::xbus_data_t dataout,
   input  iob_pkg::kb_event_s   kb,
   input  iob_pkg::ms_event_s   ms,
   output logic                 interrupt,
   output logic [7:0]           vector
);

   iob_pkg::iob_access_s access;
   xbus_pkg::xbus_data_t us_count;
   xbus_pkg::xbus_data_t hz60_count;
   xbus_pkg::xbus_data_t rd_data;
   logic                 hz60_tick;
   logic                 hz60_start;
   logic                 done;

   iob_decode u_decode (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .bus    (bus),
      .decode (decode),
      .access (access)
   );

   iob_regs u_regs (
      .clk        (clk),
      .reset      (reset),
      .access     (access),
      .kb         (kb),
      .ms         (ms),
      .us_count   (us_count),
      .hz60_count (hz60_count),
      .hz60_tick  (hz60_tick),
      .hz60_start (hz60_start),
      .rd_data    (rd_data),
      .done       (done),
      .interrupt  (interrupt),
      .vector     (vector)
   );

   iob_timers u_timers (
      .clk        (clk),
      .reset      (reset),
      .hz60_start (hz60_start),
      .us_count   (us_count),
      .hz60_count (hz60_count),
      .hz60_tick  (hz60_tick)
   );

   iob_respond u_respond (
      .clk     (clk),
      .reset   (reset),
      .done    (done),
      .rd_data (rd_data),
      .ack     (ack),
      .dataout (dataout)
   );

endmodule

// File: list.f
+incdir+logic
logic/xbus_pkg.sv
logic/iob_pkg.sv
bench/iob_tb.sv
logic/iob_decode.sv
logic/iob_regs.sv
logic/iob_timers.sv
logic/iob_respond.sv
logic/iob_top.sv
